/* wb_upsize_pkg.sv */
////////////////////
// Shared constants for the Wishbone 32-to-64 upsizer
// Used by the RTL and the testbench through scoped names
////////////////////

`default_nettype none

package wb_upsize_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Byte address width on both sides
  localparam int AW = 32;

  // Cycle-type and burst-type field widths
  localparam int CTI_W = 3;
  localparam int BTE_W = 2;

  ////////////////////
  // Cycle-type codes
  ////////////////////

  // Classic cycle, the only kind issued on the wide side
  localparam logic [CTI_W-1:0] CTI_CLASSIC = 3'b000;
  // Burst codes a narrow master may present
  localparam logic [CTI_W-1:0] CTI_CONST   = 3'b001;
  localparam logic [CTI_W-1:0] CTI_INCR    = 3'b010;
  localparam logic [CTI_W-1:0] CTI_EOB     = 3'b111;

  ////////////////////
  // Burst-type codes
  ////////////////////

  // Linear burst, driven on the wide side
  localparam logic [BTE_W-1:0] BTE_LINEAR  = 2'b00;
  localparam logic [BTE_W-1:0] BTE_WRAP4   = 2'b01;

endpackage

`default_nettype wire

/* wb_upsize_ctrl.sv */
////////////////////
// Upsizer control FSM
// Turns one narrow Wishbone request into one classic wide cycle
// and returns the wide response on the narrow side one cycle later
////////////////////

`default_nettype none

module wb_upsize_ctrl #(
  parameter int DW_IN = 32,
  parameter int SCALE = 2
) (
  input  wire                              wbm_m2s_cyc,
  input  wire                              rst_i,
  // Narrow side request
  input  wire  [wb_upsize_pkg::AW-1:0]     wbs_adr_i,
  input  wire                              wbs_we_i,
  input  wire                              wbs_cyc_i,
  input  wire                              wbs_stb_i,
  // Wide side response
  input  wire                              wbm_ack_i,
  input  wire                              wbm_err_i,
  input  wire                              wbm_rty_i,
  // Wide side request
  output logic [wb_upsize_pkg::AW-1:0]     wbm_adr_o,
  output logic                             wbm_we_o,
  output logic                             wbm_cyc_o,
  output logic                             wbm_stb_o,
  output logic [wb_upsize_pkg::CTI_W-1:0]  wbm_cti_o,
  output logic [wb_upsize_pkg::BTE_W-1:0]  wbm_bte_o,
  // Narrow side response
  output logic                             wbs_ack_o,
  output logic                             wbs_err_o,
  output logic                             wbs_rty_o,
  // Datapath strobes
  output logic                             req_load_o,
  output logic [$clog2(SCALE)-1:0]         lane_o,
  output logic                             rsp_load_o
);

  localparam int AW       = wb_upsize_pkg::AW;
  // Byte offset bits inside a narrow word
  localparam int WORD_LSB = $clog2(DW_IN / 8);
  // Byte offset bits inside a wide word
  localparam int ADR_LSB  = $clog2(DW_IN * SCALE / 8);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WIDE,
    ST_RESP
  } state_t;

  state_t state_q;
  logic   wide_rsp;

  ////////////////////
  // Strobes
  ////////////////////

  // Accept only from idle
  assign req_load_o = (state_q == ST_IDLE) && wbs_cyc_i && wbs_stb_i;
  // Any wide response ends the cycle
  assign wide_rsp   = wbm_ack_i || wbm_err_i || wbm_rty_i;
  assign rsp_load_o = (state_q == ST_WIDE) && wide_rsp;

  // Wide cycle lives exactly as long as the WIDE state
  assign wbm_cyc_o = (state_q == ST_WIDE);
  assign wbm_stb_o = (state_q == ST_WIDE);
  // Bursts collapse to single classic accesses
  assign wbm_cti_o = wb_upsize_pkg::CTI_CLASSIC;
  assign wbm_bte_o = wb_upsize_pkg::BTE_LINEAR;

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge wbm_m2s_cyc) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (req_load_o) state_q <= ST_WIDE;
        ST_WIDE: if (wide_rsp) state_q <= ST_RESP;
        // One-cycle response, master still holds stb here
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Narrow response pulse, ack wins over err over rty
  always_ff @(posedge wbm_m2s_cyc) begin
    if (rst_i) begin
      wbs_ack_o <= 1'b0;
      wbs_err_o <= 1'b0;
      wbs_rty_o <= 1'b0;
    end else begin
      wbs_ack_o <= rsp_load_o && wbm_ack_i;
      wbs_err_o <= rsp_load_o && !wbm_ack_i && wbm_err_i;
      wbs_rty_o <= rsp_load_o && !wbm_ack_i && !wbm_err_i && wbm_rty_i;
    end
  end

  // Request capture, address aligned down to the wide word
  always_ff @(posedge wbm_m2s_cyc) begin
    if (req_load_o) begin
      wbm_adr_o <= {wbs_adr_i[AW-1:ADR_LSB], {ADR_LSB{1'b0}}};
      wbm_we_o  <= wbs_we_i;
      // Low word-address bits pick the lane
      lane_o    <= wbs_adr_i[ADR_LSB-1:WORD_LSB];
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // One response kind per narrow cycle
  a_rsp_onehot : assert property (@(posedge wbm_m2s_cyc) disable iff (rst_i)
    $onehot0({wbs_ack_o, wbs_err_o, wbs_rty_o}));

  // Wide strobe only drops after the slave answered
  a_stb_fall : assert property (@(posedge wbm_m2s_cyc) disable iff (rst_i)
    $fell(wbm_stb_o) |-> $past(wide_rsp));

  // Narrow master must hold its request until the response
  a_no_abort : assert property (@(posedge wbm_m2s_cyc) disable iff (rst_i)
    (state_q != ST_IDLE) |-> (wbs_cyc_i && wbs_stb_i));

endmodule

`default_nettype wire

/* wb_write_lane.sv */
////////////////////
// Write datapath of the upsizer
// Registers narrow data on every lane and a select for the addressed lane only
////////////////////

`default_nettype none

module wb_write_lane #(
  parameter int DW_IN = 32,
  parameter int SCALE = 2
) (
  input  wire                          wbm_m2s_cyc,
  input  wire                          rst_i,
  input  wire                          req_load_i,
  input  wire  [wb_upsize_pkg::AW-1:0] wbs_adr_i,
  input  wire  [DW_IN-1:0]             wbs_dat_i,
  input  wire  [DW_IN/8-1:0]           wbs_sel_i,
  output logic [DW_IN*SCALE-1:0]       wbm_dat_o,
  output logic [DW_IN*SCALE/8-1:0]     wbm_sel_o
);

  localparam int SB_IN    = DW_IN / 8;
  localparam int WORD_LSB = $clog2(SB_IN);
  localparam int ADR_LSB  = $clog2(DW_IN * SCALE / 8);

  // Lane picked by the request address
  logic [$clog2(SCALE)-1:0] req_lane;
  // Per-lane select activity, for the check below
  logic [SCALE-1:0]         lane_nz;

  assign req_lane = wbs_adr_i[ADR_LSB-1:WORD_LSB];

  ////////////////////
  // Capture
  ////////////////////

  // Same word on every lane, sel decides which bytes land
  always_ff @(posedge wbm_m2s_cyc) begin
    if (req_load_i) begin
      wbm_dat_o <= {SCALE{wbs_dat_i}};
    end
  end

  // Zero select outside the addressed lane
  always_ff @(posedge wbm_m2s_cyc) begin
    if (rst_i) begin
      wbm_sel_o <= '0;
    end else if (req_load_i) begin
      for (int l = 0; l < SCALE; l++) begin
        wbm_sel_o[l*SB_IN +: SB_IN] <= (req_lane == l) ? wbs_sel_i : '0;
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  for (genvar g = 0; g < SCALE; g++) begin : g_lane_nz
    assign lane_nz[g] = |wbm_sel_o[g*SB_IN +: SB_IN];
  end

  // At most one lane may carry byte enables
  a_one_lane : assert property (@(posedge wbm_m2s_cyc) disable iff (rst_i)
    $onehot0(lane_nz));

endmodule

`default_nettype wire

/* wb_read_lane.sv */
////////////////////
// Read datapath of the upsizer
// Captures the addressed narrow word of the wide read data on response
////////////////////

`default_nettype none

module wb_read_lane #(
  parameter int DW_IN = 32,
  parameter int SCALE = 2
) (
  input  wire                       wbm_m2s_cyc,
  input  wire                       rst_i,
  input  wire                       rsp_load_i,
  input  wire  [$clog2(SCALE)-1:0]  lane_i,
  input  wire  [DW_IN*SCALE-1:0]    wbm_dat_i,
  output logic [DW_IN-1:0]          wbs_dat_o
);

  // Narrow word at the registered lane
  logic [DW_IN-1:0] lane_word;

  ////////////////////
  // Lane select
  ////////////////////

  // Indexed part-select, lane 0 is the low word
  assign lane_word = wbm_dat_i[lane_i*DW_IN +: DW_IN];

  ////////////////////
  // Hold register
  ////////////////////

  // Loaded with the wide response edge
  // Stays put until the next response, so it covers the narrow ack cycle
  always_ff @(posedge wbm_m2s_cyc) begin
    if (rst_i) begin
      wbs_dat_o <= '0;
    end else if (rsp_load_i) begin
      wbs_dat_o <= lane_word;
    end
  end

endmodule

`default_nettype wire

/* wb_wide_ram.sv */
////////////////////
// Wide Wishbone RAM slave with byte selects
// One registered response per request, err for word indexes past the end
////////////////////

`default_nettype none

module wb_wide_ram #(
  parameter int DW_IN     = 32,
  parameter int SCALE     = 2,
  parameter int MEM_WORDS = 1024
) (
  input  wire                              wbm_m2s_cyc,
  input  wire                              rst_i,
  input  wire  [wb_upsize_pkg::AW-1:0]     wb_adr_i,
  input  wire  [DW_IN*SCALE-1:0]           wb_dat_i,
  input  wire  [DW_IN*SCALE/8-1:0]         wb_sel_i,
  input  wire                              wb_we_i,
  input  wire                              wb_cyc_i,
  input  wire                              wb_stb_i,
  input  wire  [wb_upsize_pkg::CTI_W-1:0]  wb_cti_i,
  input  wire  [wb_upsize_pkg::BTE_W-1:0]  wb_bte_i,
  output logic [DW_IN*SCALE-1:0]           wb_dat_o,
  output logic                             wb_ack_o,
  output logic                             wb_err_o,
  output logic                             wb_rty_o
);

  localparam int AW      = wb_upsize_pkg::AW;
  localparam int DW      = DW_IN * SCALE;
  localparam int SW      = DW / 8;
  localparam int ADR_LSB = $clog2(SW);
  // Index width into the array
  localparam int MW      = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  ////////////////////
  // Storage and decode
  ////////////////////

  logic [DW-1:0]          mem [MEM_WORDS];

  // Full wide word index, compared before any access
  logic [AW-ADR_LSB-1:0]  word_idx;
  logic [MW-1:0]          mem_idx;
  logic                   in_range;
  // Request seen, response due next edge
  logic                   req_q;

  assign word_idx = wb_adr_i[AW-1:ADR_LSB];
  assign mem_idx  = word_idx[MW-1:0];
  assign in_range = (word_idx < MEM_WORDS);

  // Never asks for a retry
  assign wb_rty_o = 1'b0;

  ////////////////////
  // Handshake
  ////////////////////

  // New request only when neither pending nor answering
  // Master drops stb on the edge that sees the response
  always_ff @(posedge wbm_m2s_cyc) begin
    if (rst_i) begin
      req_q    <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      req_q    <= wb_cyc_i && wb_stb_i && !req_q && !wb_ack_o && !wb_err_o;
      wb_ack_o <= req_q && in_range;
      wb_err_o <= req_q && !in_range;
    end
  end

  ////////////////////
  // Array access
  ////////////////////

  // Out-of-range requests touch nothing
  always_ff @(posedge wbm_m2s_cyc) begin
    if (req_q && in_range) begin
      if (wb_we_i) begin
        for (int b = 0; b < SW; b++) begin
          if (wb_sel_i[b]) begin
            mem[mem_idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
          end
        end
      end
      // Old contents on a write, read data is don't-care then
      wb_dat_o <= mem[mem_idx];
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Only classic linear cycles arrive from the upsizer
  a_classic : assert property (@(posedge wbm_m2s_cyc) disable iff (rst_i)
    (wb_cyc_i && wb_stb_i) |->
      (wb_cti_i == wb_upsize_pkg::CTI_CLASSIC) && (wb_bte_i == wb_upsize_pkg::BTE_LINEAR));

endmodule

`default_nettype wire

/* wb_upsize_top.sv */
////////////////////
// Upsizer subsystem top level
// Narrow 32-bit Wishbone port in front of a 64-bit RAM through the upsizer
////////////////////

`default_nettype none

module wb_upsize_top #(
  parameter int DW_IN     = 32,
  parameter int SCALE     = 2,
  parameter int MEM_WORDS = 1024
) (
  input  wire                              wbm_m2s_cyc,
  input  wire                              rst_i,
  // Narrow Wishbone slave port
  input  wire  [wb_upsize_pkg::AW-1:0]     wbs_adr_i,
  input  wire  [DW_IN-1:0]                 wbs_dat_i,
  input  wire  [DW_IN/8-1:0]               wbs_sel_i,
  input  wire                              wbs_we_i,
  input  wire                              wbs_cyc_i,
  input  wire                              wbs_stb_i,
  // Burst hints accepted, every access runs classic
  input  wire  [wb_upsize_pkg::CTI_W-1:0]  wbs_cti_i,
  input  wire  [wb_upsize_pkg::BTE_W-1:0]  wbs_bte_i,
  output logic [DW_IN-1:0]                 wbs_dat_o,
  output logic                             wbs_ack_o,
  output logic                             wbs_err_o,
  output logic                             wbs_rty_o
);

  localparam int DW_OUT = DW_IN * SCALE;

  ////////////////////
  // Wide side wires
  ////////////////////

  logic [wb_upsize_pkg::AW-1:0]     wbm_adr;
  logic [DW_OUT-1:0]                wbm_dat_w;
  logic [DW_OUT/8-1:0]              wbm_sel;
  logic                             wbm_we;
  logic                             wbm_cyc;
  logic                             wbm_stb;
  logic [wb_upsize_pkg::CTI_W-1:0]  wbm_cti;
  logic [wb_upsize_pkg::BTE_W-1:0]  wbm_bte;
  logic [DW_OUT-1:0]                wbm_dat_r;
  logic                             wbm_ack;
  logic                             wbm_err;
  logic                             wbm_rty;

  // Controller to datapath strobes
  logic                             req_load;
  logic                             rsp_load;
  logic [$clog2(SCALE)-1:0]         lane;

  ////////////////////
  // Instances
  ////////////////////

  wb_upsize_ctrl #(.DW_IN(DW_IN), .SCALE(SCALE)) u_ctrl (
    .wbm_m2s_cyc (wbm_m2s_cyc),
    .rst_i       (rst_i),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_we_i    (wbs_we_i),
    .wbs_cyc_i   (wbs_cyc_i),
    .wbs_stb_i   (wbs_stb_i),
    .wbm_ack_i   (wbm_ack),
    .wbm_err_i   (wbm_err),
    .wbm_rty_i   (wbm_rty),
    .wbm_adr_o   (wbm_adr),
    .wbm_we_o    (wbm_we),
    .wbm_cyc_o   (wbm_cyc),
    .wbm_stb_o   (wbm_stb),
    .wbm_cti_o   (wbm_cti),
    .wbm_bte_o   (wbm_bte),
    .wbs_ack_o   (wbs_ack_o),
    .wbs_err_o   (wbs_err_o),
    .wbs_rty_o   (wbs_rty_o),
    .req_load_o  (req_load),
    .lane_o      (lane),
    .rsp_load_o  (rsp_load)
  );

  wb_write_lane #(.DW_IN(DW_IN), .SCALE(SCALE)) u_write_lane (
    .wbm_m2s_cyc (wbm_m2s_cyc),
    .rst_i       (rst_i),
    .req_load_i  (req_load),
    .wbs_adr_i   (wbs_adr_i),
    .wbs_dat_i   (wbs_dat_i),
    .wbs_sel_i   (wbs_sel_i),
    .wbm_dat_o   (wbm_dat_w),
    .wbm_sel_o   (wbm_sel)
  );

  wb_read_lane #(.DW_IN(DW_IN), .SCALE(SCALE)) u_read_lane (
    .wbm_m2s_cyc (wbm_m2s_cyc),
    .rst_i       (rst_i),
    .rsp_load_i  (rsp_load),
    .lane_i      (lane),
    .wbm_dat_i   (wbm_dat_r),
    .wbs_dat_o   (wbs_dat_o)
  );

  wb_wide_ram #(.DW_IN(DW_IN), .SCALE(SCALE), .MEM_WORDS(MEM_WORDS)) u_ram (
    .wbm_m2s_cyc (wbm_m2s_cyc),
    .rst_i       (rst_i),
    .wb_adr_i    (wbm_adr),
    .wb_dat_i    (wbm_dat_w),
    .wb_sel_i    (wbm_sel),
    .wb_we_i     (wbm_we),
    .wb_cyc_i    (wbm_cyc),
    .wb_stb_i    (wbm_stb),
    .wb_cti_i    (wbm_cti),
    .wb_bte_i    (wbm_bte),
    .wb_dat_o    (wbm_dat_r),
    .wb_ack_o    (wbm_ack),
    .wb_err_o    (wbm_err),
    .wb_rty_o    (wbm_rty)
  );

endmodule

`default_nettype wire

/* tb_wb_upsize.sv */
////////////////////
// Self-checking testbench for the Wishbone upsizer subsystem
// Runs a table of narrow cycles against a byte-wide reference memory
////////////////////

`default_nettype none

module tb_wb_upsize;

  localparam int PERIOD     = 4;
  localparam int MEM_WORDS  = 1024;
  // Bytes per wide word and per narrow word
  localparam int WIDE_BYTES = 8;
  localparam int NARROW_B   = 4;
  localparam int MAX_WAIT   = 20;
  localparam int N_FIXED    = 20;
  localparam int N_RAND     = 24;
  localparam int NROWS      = N_FIXED + N_RAND;
  // Row budget of 10 cycles plus the reset window
  localparam int WATCHDOG   = NROWS * 10 * PERIOD + 4 * PERIOD;

  // Response vector order is {rty, err, ack}
  localparam logic [2:0] RSP_ACK = 3'b001;
  localparam logic [2:0] RSP_ERR = 3'b010;

  logic        wbm_m2s_cyc;
  logic        rst_i;
  logic [31:0] wbs_adr;
  logic [31:0] wbs_dat_w;
  logic [3:0]  wbs_sel;
  logic        wbs_we;
  logic        wbs_cyc;
  logic        wbs_stb;
  logic [2:0]  wbs_cti;
  logic [1:0]  wbs_bte;
  logic [31:0] wbs_dat_r;
  logic        wbs_ack;
  logic        wbs_err;
  logic        wbs_rty;

  // Stimulus table, one narrow cycle per row
  string       row_name [NROWS];
  logic        row_we   [NROWS];
  logic [31:0] row_adr  [NROWS];
  logic [31:0] row_dat  [NROWS];
  logic [3:0]  row_sel  [NROWS];
  logic [2:0]  row_cti  [NROWS];
  logic [1:0]  row_bte  [NROWS];
  logic [2:0]  row_rsp  [NROWS];

  // Reference RAM, byte addressed
  logic [7:0]  ref_mem [MEM_WORDS * WIDE_BYTES];

  wb_upsize_top dut (
    .wbm_m2s_cyc (wbm_m2s_cyc),
    .rst_i       (rst_i),
    .wbs_adr_i   (wbs_adr),
    .wbs_dat_i   (wbs_dat_w),
    .wbs_sel_i   (wbs_sel),
    .wbs_we_i    (wbs_we),
    .wbs_cyc_i   (wbs_cyc),
    .wbs_stb_i   (wbs_stb),
    .wbs_cti_i   (wbs_cti),
    .wbs_bte_i   (wbs_bte),
    .wbs_dat_o   (wbs_dat_r),
    .wbs_ack_o   (wbs_ack),
    .wbs_err_o   (wbs_err),
    .wbs_rty_o   (wbs_rty)
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_equal(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %0h actual %0h", what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // Err once the wide word index runs past the RAM
  function automatic logic [2:0] expected_rsp(input logic [31:0] adr);
    return ((adr / WIDE_BYTES) < MEM_WORDS) ? RSP_ACK : RSP_ERR;
  endfunction

  task automatic set_row(input int r, input string name, input logic we,
                         input logic [31:0] adr, input logic [31:0] dat,
                         input logic [3:0] sel, input logic [2:0] cti,
                         input logic [2:0] rsp);
    row_name[r] = name;
    row_we[r]   = we;
    row_adr[r]  = adr;
    row_dat[r]  = dat;
    row_sel[r]  = sel;
    row_cti[r]  = cti;
    row_bte[r]  = wb_upsize_pkg::BTE_LINEAR;
    row_rsp[r]  = rsp;
  endtask

  task automatic load_table();
    logic [2:0] cti_pick [4];
    cti_pick[0] = wb_upsize_pkg::CTI_CLASSIC;
    cti_pick[1] = wb_upsize_pkg::CTI_CONST;
    cti_pick[2] = wb_upsize_pkg::CTI_INCR;
    cti_pick[3] = wb_upsize_pkg::CTI_EOB;
    // Lane steering, even and odd narrow words of wide word 0
    set_row(0, "wr_even", 1'b1, 32'h0000_0000, 32'h1122_3344, 4'hf, 3'b000, RSP_ACK);
    set_row(1, "wr_odd", 1'b1, 32'h0000_0004, 32'h5566_7788, 4'hf, 3'b000, RSP_ACK);
    set_row(2, "rd_even", 1'b0, 32'h0000_0000, 32'h0, 4'hf, 3'b000, RSP_ACK);
    set_row(3, "rd_odd", 1'b0, 32'h0000_0004, 32'h0, 4'hf, 3'b000, RSP_ACK);
    // Byte merges into wide word 1
    set_row(4, "wr_w2", 1'b1, 32'h0000_0008, 32'ha5a5_0f0f, 4'hf, 3'b000, RSP_ACK);
    set_row(5, "wr_w3", 1'b1, 32'h0000_000c, 32'hdead_beef, 4'hf, 3'b000, RSP_ACK);
    set_row(6, "wr_part_lo", 1'b1, 32'h0000_0008, 32'h0000_00cc, 4'b0001, 3'b000, RSP_ACK);
    set_row(7, "wr_part_hi", 1'b1, 32'h0000_000c, 32'h7700_0000, 4'b1000, 3'b000, RSP_ACK);
    set_row(8, "wr_part_mid", 1'b1, 32'h0000_000c, 32'h0012_3400, 4'b0110, 3'b000, RSP_ACK);
    set_row(9, "rd_w2", 1'b0, 32'h0000_0008, 32'h0, 4'hf, 3'b000, RSP_ACK);
    set_row(10, "rd_w3", 1'b0, 32'h0000_000c, 32'h0, 4'hf, 3'b000, RSP_ACK);
    // Past the end, index would alias word 0 if the RAM wrapped
    set_row(11, "wr_oor", 1'b1, 32'h0000_2000, 32'hbad0_bad0, 4'hf, 3'b000, RSP_ERR);
    set_row(12, "rd_oor", 1'b0, 32'h0000_2004, 32'h0, 4'hf, 3'b000, RSP_ERR);
    set_row(13, "rd_far_oor", 1'b0, 32'hffff_fff0, 32'h0, 4'hf, 3'b000, RSP_ERR);
    set_row(14, "rd_after_err", 1'b0, 32'h0000_0000, 32'h0, 4'hf, 3'b000, RSP_ACK);
    set_row(15, "rd_after_err_hi", 1'b0, 32'h0000_0004, 32'h0, 4'hf, 3'b000, RSP_ACK);
    // Fill the rest of the random window, with a burst code thrown in
    set_row(16, "fill_4", 1'b1, 32'h0000_0010, 32'h0bad_cafe, 4'hf, 3'b010, RSP_ACK);
    set_row(17, "fill_5", 1'b1, 32'h0000_0014, 32'h1357_9bdf, 4'hf, 3'b010, RSP_ACK);
    set_row(18, "fill_6", 1'b1, 32'h0000_0018, 32'h2468_ace0, 4'hf, 3'b010, RSP_ACK);
    set_row(19, "fill_7", 1'b1, 32'h0000_001c, 32'hfeed_f00d, 4'hf, 3'b111, RSP_ACK);
    // Random traffic over the first 8 narrow words
    for (int i = 0; i < N_RAND; i++) begin
      set_row(N_FIXED + i, $sformatf("rand_%0d", i), 1'($urandom % 2),
              ($urandom % 8) * NARROW_B, $urandom, 4'($urandom % 16),
              cti_pick[$urandom % 4], 3'b000);
      row_bte[N_FIXED + i] = 2'($urandom % 4);
      row_rsp[N_FIXED + i] = expected_rsp(row_adr[N_FIXED + i]);
    end
  endtask

  // One narrow cycle, entered and left 1 unit after a rising edge
  task automatic run_row(input int r);
    int          waited;
    logic [2:0]  rsp;
    logic [31:0] base;
    logic [31:0] exp_dat;
    string       name;
    name      = row_name[r];
    wbs_adr   = row_adr[r];
    wbs_dat_w = row_dat[r];
    wbs_sel   = row_sel[r];
    wbs_we    = row_we[r];
    wbs_cti   = row_cti[r];
    wbs_bte   = row_bte[r];
    wbs_cyc   = 1'b1;
    wbs_stb   = 1'b1;
    waited    = 0;
    rsp       = 3'b000;
    // First edge is the sampling edge
    while (rsp == 3'b000 && waited < MAX_WAIT) begin
      @(posedge wbm_m2s_cyc);
      #1;
      waited++;
      rsp = {wbs_rty, wbs_err, wbs_ack};
    end
    if (rsp == 3'b000) begin
      abort_run($sformatf("no response within %0d cycles for %s", MAX_WAIT, name));
    end else begin
      check_equal({name, " rsp"}, row_rsp[r], rsp);
      // Three edges past the sampling edge
      check_equal({name, " latency"}, 3, waited - 1);
      base = row_adr[r] & ~32'h3;
      if (row_rsp[r] == RSP_ACK) begin
        if (row_we[r]) begin
          for (int b = 0; b < NARROW_B; b++) begin
            if (row_sel[r][b]) begin
              ref_mem[base + b] = row_dat[r][b*8 +: 8];
            end
          end
        end else begin
          exp_dat = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
          check_equal({name, " data"}, exp_dat, wbs_dat_r);
        end
      end
      // Master holds stb through the edge that sees the response
      @(posedge wbm_m2s_cyc);
      #1;
      check_equal({name, " single pulse"}, 3'b000, {wbs_rty, wbs_err, wbs_ack});
      wbs_cyc = 1'b0;
      wbs_stb = 1'b0;
    end
  endtask

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    wbm_m2s_cyc = 1'b0;
    forever #(PERIOD / 2) wbm_m2s_cyc = ~wbm_m2s_cyc;
  end

  initial begin
    #(WATCHDOG);
    abort_run("watchdog expired before all table rows completed");
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    void'($urandom(32'h8862));
    rst_i     = 1'b1;
    wbs_adr   = '0;
    wbs_dat_w = '0;
    wbs_sel   = '0;
    wbs_we    = 1'b0;
    wbs_cyc   = 1'b0;
    wbs_stb   = 1'b0;
    wbs_cti   = wb_upsize_pkg::CTI_CLASSIC;
    wbs_bte   = wb_upsize_pkg::BTE_LINEAR;
    load_table();
    repeat (4) @(posedge wbm_m2s_cyc);
    #1;
    rst_i = 1'b0;
    // Quiet bus straight out of reset
    check_equal("reset_rsp", 3'b000, {wbs_rty, wbs_err, wbs_ack});
    // Rows run back to back
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
wb_upsize_pkg.sv
wb_upsize_ctrl.sv
wb_write_lane.sv
wb_read_lane.sv
wb_wide_ram.sv
wb_upsize_top.sv
tb_wb_upsize.sv

/* Bender.yml */
package:
  name: wb_upsize

sources:
  # Package first, then leaf modules, then the top level
  - wb_upsize_pkg.sv
  - wb_upsize_ctrl.sv
  - wb_write_lane.sv
  - wb_read_lane.sv
  - wb_wide_ram.sv
  - wb_upsize_top.sv
  - target: simulation
    files:
      - tb_wb_upsize.sv
